//--- Bender.yml
package:
  name: cl_sim_shell

sources:
  - files:
      - source/ddr_axi_pkg.sv
      - source/cl_shell_pkg.sv
      - source/axi_reg_slice.sv
      - source/ddr_axi_bridge.sv
      - source/tick_divider.sv
      - source/dbg_counter.sv
      - source/cl_sim_shell.sv
  - target: simulation
    files:
      - verif/tb_cl_sim_shell.sv

//--- cl_sim_shell.f
source/ddr_axi_pkg.sv
source/cl_shell_pkg.sv
source/axi_reg_slice.sv
source/ddr_axi_bridge.sv
source/tick_divider.sv
source/dbg_counter.sv
source/cl_sim_shell.sv
verif/tb_cl_sim_shell.sv

//--- source/axi_reg_slice.sv
// Two-entry valid/ready buffer placed on each bridge channel.
// Presents the oldest entry; ready comes from a flop so no path crosses the slice.
module axi_reg_slice #(
  parameter int WIDTH = 8
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic             main_valid;   // head entry present
  logic             skid_valid;   // second entry present
  logic [WIDTH-1:0] main_data;    // head payload
  logic [WIDTH-1:0] skid_data;    // payload caught while head stalls
  logic             push;
  logic             pop;
  logic             head_free;    // head is empty or leaves on this edge

  assign push      = in_valid & in_ready;
  assign pop       = main_valid & out_ready;
  assign head_free = pop | ~main_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  // occupancy and registered ready
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;          // held low until the first cycle after reset
    end
    else if (head_free)
    begin
      main_valid <= skid_valid | push;   // skid moves up, or new item enters
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end
    else if (push)
    begin
      skid_valid <= 1'b1;          // head stalled, park item in skid
      in_ready   <= 1'b0;          // both entries taken
    end
  end

  // payload
  always_ff @(posedge clk_main_a0)
  begin
    if (head_free)
      main_data <= skid_valid ? skid_data : in_data;   // oldest first
    if (in_ready)
      skid_data <= in_data;        // only kept when the head stalls
  end

endmodule

//--- source/cl_shell_pkg.sv
// Identity, status and version words of the shell, and the debug counter widths.
// Imported by the top level, the counter modules and the testbench.
package cl_shell_pkg;

  //------------------------------------------------------------
  // identity and status
  //------------------------------------------------------------
  localparam logic [31:0] CL_ID0     = 32'hF000_1D0F;   // device, vendor
  localparam logic [31:0] CL_ID1     = 32'h1D51_FEDC;   // subsystem ids
  localparam logic [31:0] CL_STATUS0 = 32'h0000_0FF0;   // fixed status pattern
  localparam logic [31:0] CL_VERSION = 32'hEEEE_EE00;   // build version word

  //------------------------------------------------------------
  // debug counter
  //------------------------------------------------------------
  localparam int TICK_W = 8;    // tick divider width
  localparam int CNT_W  = 16;   // event counter width

endpackage

//--- source/cl_sim_shell.sv
// Top level of the shell logic: reset synchronizer, identity and status words,
// the simulator to DDR bridge and the debug counter, all on clk_main_a0.
module cl_sim_shell import ddr_axi_pkg::*, cl_shell_pkg::*; (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n,     // raw reset, synchronized below
  output logic [31:0]           cl_id0,
  output logic [31:0]           cl_id1,
  output logic [31:0]           cl_status0,
  output logic [31:0]           cl_status1,
  // simulator memory port
  input  logic                  sim_aw_valid,
  output logic                  sim_aw_ready,
  input  logic [AXI_ID_W-1:0]   sim_aw_id,
  input  logic [SIM_ADDR_W-1:0] sim_aw_addr,
  input  logic [AXI_LEN_W-1:0]  sim_aw_len,
  input  logic                  sim_w_valid,
  output logic                  sim_w_ready,
  input  logic [SIM_DATA_W-1:0] sim_w_data,
  input  logic [SIM_STRB_W-1:0] sim_w_strb,
  input  logic                  sim_w_last,
  output logic                  sim_b_valid,
  input  logic                  sim_b_ready,
  output logic [AXI_ID_W-1:0]   sim_b_id,
  output logic [AXI_RESP_W-1:0] sim_b_resp,
  input  logic                  sim_ar_valid,
  output logic                  sim_ar_ready,
  input  logic [AXI_ID_W-1:0]   sim_ar_id,
  input  logic [SIM_ADDR_W-1:0] sim_ar_addr,
  input  logic [AXI_LEN_W-1:0]  sim_ar_len,
  output logic                  sim_r_valid,
  input  logic                  sim_r_ready,
  output logic [AXI_ID_W-1:0]   sim_r_id,
  output logic [SIM_DATA_W-1:0] sim_r_data,
  output logic [AXI_RESP_W-1:0] sim_r_resp,
  output logic                  sim_r_last,
  // DDR port
  output logic                  ddr_aw_valid,
  input  logic                  ddr_aw_ready,
  output logic [AXI_ID_W-1:0]   ddr_aw_id,
  output logic [DDR_ADDR_W-1:0] ddr_aw_addr,
  output logic [AXI_LEN_W-1:0]  ddr_aw_len,
  output logic [2:0]            ddr_aw_size,
  output logic                  ddr_w_valid,
  input  logic                  ddr_w_ready,
  output logic [DDR_DATA_W-1:0] ddr_w_data,
  output logic [DDR_STRB_W-1:0] ddr_w_strb,
  output logic                  ddr_w_last,
  input  logic                  ddr_b_valid,
  output logic                  ddr_b_ready,
  input  logic [AXI_ID_W-1:0]   ddr_b_id,
  input  logic [AXI_RESP_W-1:0] ddr_b_resp,
  output logic                  ddr_ar_valid,
  input  logic                  ddr_ar_ready,
  output logic [AXI_ID_W-1:0]   ddr_ar_id,
  output logic [DDR_ADDR_W-1:0] ddr_ar_addr,
  output logic [AXI_LEN_W-1:0]  ddr_ar_len,
  output logic [2:0]            ddr_ar_size,
  input  logic                  ddr_r_valid,
  output logic                  ddr_r_ready,
  input  logic [AXI_ID_W-1:0]   ddr_r_id,
  input  logic [DDR_DATA_W-1:0] ddr_r_data,
  input  logic [AXI_RESP_W-1:0] ddr_r_resp,
  input  logic                  ddr_r_last,
  // debug counter controls and results
  input  logic                  cnt_enable,
  input  logic                  cnt_load,
  input  logic                  cnt_clear,
  input  logic                  cnt_oneshot,
  input  logic [TICK_W-1:0]     tick_value,
  input  logic [CNT_W-1:0]      cnt_load_value,
  input  logic [CNT_W-1:0]      cnt_watermark,
  output logic                  tick,
  output logic [TICK_W-1:0]     tick_cnt,
  output logic [CNT_W-1:0]      cnt,
  output logic                  cnt_ge_watermark
);

  logic rst_meta_n;   // first synchronizer stage
  logic rst_sync_n;   // reset seen by everything below

  //------------------------------------------------------------
  // reset synchronizer, two flops
  //------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      rst_meta_n <= 1'b0;
      rst_sync_n <= 1'b0;
    end
    else
    begin
      rst_meta_n <= 1'b1;
      rst_sync_n <= rst_meta_n;   // released two edges after rst_main_n
    end
  end

  // fixed identity, status and beat size
  assign cl_id0      = CL_ID0;
  assign cl_id1      = CL_ID1;
  assign cl_status0  = CL_STATUS0;
  assign cl_status1  = CL_VERSION;
  assign ddr_aw_size = DDR_SIZE_CODE;   // every DDR beat is 64 bytes
  assign ddr_ar_size = DDR_SIZE_CODE;

  // channel ports share names with the top, only the reset differs
  ddr_axi_bridge u_bridge (
    .rst_main_n (rst_sync_n),
    .*
  );

  dbg_counter u_dbg_counter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n       (rst_sync_n),
    .cnt_enable       (cnt_enable),
    .cnt_load         (cnt_load),
    .cnt_clear        (cnt_clear),
    .cnt_oneshot      (cnt_oneshot),
    .tick_value       (tick_value),
    .cnt_load_value   (cnt_load_value),
    .cnt_watermark    (cnt_watermark),
    .tick             (tick),
    .tick_cnt         (tick_cnt),
    .cnt              (cnt),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

endmodule

//--- source/dbg_counter.sv
// Debug event counter with load, clear, one-shot saturation and watermark flag.
// Controls pass through one register stage before they act.
module dbg_counter import cl_shell_pkg::*; (
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  input  logic              cnt_enable,
  input  logic              cnt_load,
  input  logic              cnt_clear,
  input  logic              cnt_oneshot,
  input  logic [TICK_W-1:0] tick_value,
  input  logic [CNT_W-1:0]  cnt_load_value,
  input  logic [CNT_W-1:0]  cnt_watermark,
  output logic              tick,
  output logic [TICK_W-1:0] tick_cnt,
  output logic [CNT_W-1:0]  cnt,
  output logic              cnt_ge_watermark
);

  logic              enable_q;
  logic              load_q;
  logic              clear_q;
  logic              oneshot_q;      // saturate instead of wrapping
  logic [TICK_W-1:0] tick_value_q;
  logic [CNT_W-1:0]  load_value_q;
  logic [CNT_W-1:0]  watermark_q;

  // control register stage
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      enable_q     <= 1'b0;
      load_q       <= 1'b0;
      clear_q      <= 1'b0;
      oneshot_q    <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end
    else
    begin
      enable_q     <= cnt_enable;
      load_q       <= cnt_load;
      clear_q      <= cnt_clear;
      oneshot_q    <= cnt_oneshot;
      tick_value_q <= tick_value;
      load_value_q <= cnt_load_value;
      watermark_q  <= cnt_watermark;
    end
  end

  tick_divider u_tick_divider (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .enable      (enable_q),
    .clear       (clear_q),
    .tick_value  (tick_value_q),
    .tick_cnt    (tick_cnt),
    .tick        (tick)          // already gated by enable
  );

  // event counter, clear wins over load
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n || clear_q)
      cnt <= '0;
    else if (load_q)
      cnt <= load_value_q;
    else if (tick && !(oneshot_q && (&cnt)))
      cnt <= cnt + 1'b1;         // wraps unless one-shot holds all ones
  end

  assign cnt_ge_watermark = (cnt >= watermark_q);

endmodule

//--- source/ddr_axi_bridge.sv
// Adapts the 64-bit simulator memory port to the 512-bit DDR port.
// Every channel passes through its own axi_reg_slice; AW and AR turn beats into bytes.
module ddr_axi_bridge import ddr_axi_pkg::*; (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n,
  // simulator side
  input  logic                  sim_aw_valid,
  output logic                  sim_aw_ready,
  input  logic [AXI_ID_W-1:0]   sim_aw_id,
  input  logic [SIM_ADDR_W-1:0] sim_aw_addr,     // beat address
  input  logic [AXI_LEN_W-1:0]  sim_aw_len,
  input  logic                  sim_w_valid,
  output logic                  sim_w_ready,
  input  logic [SIM_DATA_W-1:0] sim_w_data,
  input  logic [SIM_STRB_W-1:0] sim_w_strb,
  input  logic                  sim_w_last,
  output logic                  sim_b_valid,
  input  logic                  sim_b_ready,
  output logic [AXI_ID_W-1:0]   sim_b_id,
  output logic [AXI_RESP_W-1:0] sim_b_resp,
  input  logic                  sim_ar_valid,
  output logic                  sim_ar_ready,
  input  logic [AXI_ID_W-1:0]   sim_ar_id,
  input  logic [SIM_ADDR_W-1:0] sim_ar_addr,     // beat address
  input  logic [AXI_LEN_W-1:0]  sim_ar_len,
  output logic                  sim_r_valid,
  input  logic                  sim_r_ready,
  output logic [AXI_ID_W-1:0]   sim_r_id,
  output logic [SIM_DATA_W-1:0] sim_r_data,
  output logic [AXI_RESP_W-1:0] sim_r_resp,
  output logic                  sim_r_last,
  // DDR side
  output logic                  ddr_aw_valid,
  input  logic                  ddr_aw_ready,
  output logic [AXI_ID_W-1:0]   ddr_aw_id,
  output logic [DDR_ADDR_W-1:0] ddr_aw_addr,     // byte address
  output logic [AXI_LEN_W-1:0]  ddr_aw_len,
  output logic                  ddr_w_valid,
  input  logic                  ddr_w_ready,
  output logic [DDR_DATA_W-1:0] ddr_w_data,
  output logic [DDR_STRB_W-1:0] ddr_w_strb,
  output logic                  ddr_w_last,
  input  logic                  ddr_b_valid,
  output logic                  ddr_b_ready,
  input  logic [AXI_ID_W-1:0]   ddr_b_id,
  input  logic [AXI_RESP_W-1:0] ddr_b_resp,
  output logic                  ddr_ar_valid,
  input  logic                  ddr_ar_ready,
  output logic [AXI_ID_W-1:0]   ddr_ar_id,
  output logic [DDR_ADDR_W-1:0] ddr_ar_addr,     // byte address
  output logic [AXI_LEN_W-1:0]  ddr_ar_len,
  input  logic                  ddr_r_valid,
  output logic                  ddr_r_ready,
  input  logic [AXI_ID_W-1:0]   ddr_r_id,
  input  logic [DDR_DATA_W-1:0] ddr_r_data,
  input  logic [AXI_RESP_W-1:0] ddr_r_resp,
  input  logic                  ddr_r_last
);

  ddr_addr_u             aw_addr;    // write beat placed into a byte address
  ddr_addr_u             ar_addr;    // read beat placed into a byte address
  logic [SIM_DATA_W-1:0] w_data_q;   // narrow write data leaving the slice
  logic [SIM_STRB_W-1:0] w_strb_q;   // narrow strobes leaving the slice

  // beat index lands above the 3 offset bits, so byte address = beat * 8
  always_comb
  begin
    aw_addr.parts.upper  = '0;
    aw_addr.parts.beat   = sim_aw_addr;
    aw_addr.parts.offset = '0;
    ar_addr.parts.upper  = '0;
    ar_addr.parts.beat   = sim_ar_addr;
    ar_addr.parts.offset = '0;
  end

  //------------------------------------------------------------
  // request channels, simulator to DDR
  //------------------------------------------------------------
  axi_reg_slice #(.WIDTH(AXI_ID_W + DDR_ADDR_W + AXI_LEN_W)) u_aw_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sim_aw_valid),
    .in_ready    (sim_aw_ready),
    .in_data     ({sim_aw_id, aw_addr.byte_addr, sim_aw_len}),
    .out_valid   (ddr_aw_valid),
    .out_ready   (ddr_aw_ready),
    .out_data    ({ddr_aw_id, ddr_aw_addr, ddr_aw_len})
  );

  // data kept narrow in the slice, widened on the way out
  axi_reg_slice #(.WIDTH(SIM_DATA_W + SIM_STRB_W + 1)) u_w_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sim_w_valid),
    .in_ready    (sim_w_ready),
    .in_data     ({sim_w_data, sim_w_strb, sim_w_last}),
    .out_valid   (ddr_w_valid),
    .out_ready   (ddr_w_ready),
    .out_data    ({w_data_q, w_strb_q, ddr_w_last})
  );

  assign ddr_w_data = {{(DDR_DATA_W - SIM_DATA_W){1'b0}}, w_data_q};   // low lanes only
  assign ddr_w_strb = {{(DDR_STRB_W - SIM_STRB_W){1'b0}}, w_strb_q};

  axi_reg_slice #(.WIDTH(AXI_ID_W + DDR_ADDR_W + AXI_LEN_W)) u_ar_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (sim_ar_valid),
    .in_ready    (sim_ar_ready),
    .in_data     ({sim_ar_id, ar_addr.byte_addr, sim_ar_len}),
    .out_valid   (ddr_ar_valid),
    .out_ready   (ddr_ar_ready),
    .out_data    ({ddr_ar_id, ddr_ar_addr, ddr_ar_len})
  );

  //------------------------------------------------------------
  // response channels, DDR to simulator
  //------------------------------------------------------------
  axi_reg_slice #(.WIDTH(AXI_ID_W + AXI_RESP_W)) u_b_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (ddr_b_valid),
    .in_ready    (ddr_b_ready),
    .in_data     ({ddr_b_id, ddr_b_resp}),
    .out_valid   (sim_b_valid),
    .out_ready   (sim_b_ready),
    .out_data    ({sim_b_id, sim_b_resp})
  );

  // only the low 64 bits of each DDR beat carry simulator data
  axi_reg_slice #(.WIDTH(AXI_ID_W + SIM_DATA_W + AXI_RESP_W + 1)) u_r_slice (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .in_valid    (ddr_r_valid),
    .in_ready    (ddr_r_ready),
    .in_data     ({ddr_r_id, ddr_r_data[SIM_DATA_W-1:0], ddr_r_resp, ddr_r_last}),
    .out_valid   (sim_r_valid),
    .out_ready   (sim_r_ready),
    .out_data    ({sim_r_id, sim_r_data, sim_r_resp, sim_r_last})
  );

endmodule

//--- source/ddr_axi_pkg.sv
// Widths and address layout shared by the simulator memory port and the DDR port.
// Imported by the bridge, the top level and the testbench.
package ddr_axi_pkg;

  //------------------------------------------------------------
  // simulator side
  //------------------------------------------------------------
  localparam int SIM_DATA_W    = 64;   // one simulator beat
  localparam int SIM_STRB_W    = 8;    // byte strobes for one beat
  localparam int SIM_ADDR_W    = 31;   // beat index, not bytes
  localparam int BEAT_OFFSET_W = 3;    // byte offset inside an 8-byte beat

  //------------------------------------------------------------
  // DDR side
  //------------------------------------------------------------
  localparam int DDR_DATA_W = 512;
  localparam int DDR_STRB_W = 64;
  localparam int DDR_ADDR_W = 64;      // byte address

  // common AXI fields
  localparam int AXI_ID_W   = 16;
  localparam int AXI_LEN_W  = 8;
  localparam int AXI_RESP_W = 2;

  // 64-byte beats on the DDR port
  localparam logic [2:0] DDR_SIZE_CODE = 3'b110;

  // bits above the beat index in the DDR byte address
  localparam int ADDR_PAD_W = DDR_ADDR_W - SIM_ADDR_W - BEAT_OFFSET_W;

  // one DDR address word, seen flat or split into beat and offset
  typedef union packed {
    logic [DDR_ADDR_W-1:0] byte_addr;      // flat view for the DDR port
    struct packed {
      logic [ADDR_PAD_W-1:0]    upper;     // zero padding
      logic [SIM_ADDR_W-1:0]    beat;      // simulator beat index
      logic [BEAT_OFFSET_W-1:0] offset;    // always 0, beats are aligned
    } parts;
  } ddr_addr_u;

endpackage

//--- source/tick_divider.sv
// Cycle counter that marks a tick every tick_value + 1 enabled cycles.
// Drives the event counter inside dbg_counter.
module tick_divider import cl_shell_pkg::*; (
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  input  logic              enable,
  input  logic              clear,
  input  logic [TICK_W-1:0] tick_value,   // terminal count
  output logic [TICK_W-1:0] tick_cnt,
  output logic              tick
);

  logic at_terminal;   // count reached the programmed value

  assign at_terminal = (tick_cnt >= tick_value);
  assign tick        = enable & at_terminal;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      tick_cnt <= '0;
    else if (clear)
      tick_cnt <= '0;
    else if (enable)
      tick_cnt <= at_terminal ? '0 : tick_cnt + 1'b1;   // wrap at terminal
  end

endmodule

//--- verif/tb_cl_sim_shell.sv
// Random-stimulus testbench for cl_sim_shell with per-channel scoreboards and a counter model.
// Runs random traffic, then a directed one-shot/wrap test, then drains the bridge.
module tb_cl_sim_shell import ddr_axi_pkg::*, cl_shell_pkg::*; ();

  localparam int RESET_CYCLES    = 16;
  localparam int TRAFFIC_CYCLES  = 4000;
  localparam int DIRECTED_CYCLES = 64;
  localparam int DRAIN_CYCLES    = 200;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + TRAFFIC_CYCLES + DIRECTED_CYCLES + DRAIN_CYCLES;
  localparam int AW_W = AXI_ID_W + DDR_ADDR_W + AXI_LEN_W;     // id, byte address, len
  localparam int W_W  = SIM_DATA_W + SIM_STRB_W + 1;           // data, strobe, last
  localparam int B_W  = AXI_ID_W + AXI_RESP_W;
  localparam int R_W  = AXI_ID_W + SIM_DATA_W + AXI_RESP_W + 1;

  logic clk_main_a0, rst_main_n;
  logic [31:0] cl_id0, cl_id1, cl_status0, cl_status1;
  logic sim_aw_valid, sim_aw_ready, sim_w_valid, sim_w_ready, sim_w_last;
  logic sim_b_valid, sim_b_ready, sim_ar_valid, sim_ar_ready;
  logic sim_r_valid, sim_r_ready, sim_r_last;
  logic [AXI_ID_W-1:0] sim_aw_id, sim_b_id, sim_ar_id, sim_r_id;
  logic [SIM_ADDR_W-1:0] sim_aw_addr, sim_ar_addr;
  logic [AXI_LEN_W-1:0] sim_aw_len, sim_ar_len;
  logic [SIM_DATA_W-1:0] sim_w_data, sim_r_data;
  logic [SIM_STRB_W-1:0] sim_w_strb;
  logic [AXI_RESP_W-1:0] sim_b_resp, sim_r_resp;
  logic ddr_aw_valid, ddr_aw_ready, ddr_w_valid, ddr_w_ready, ddr_w_last;
  logic ddr_b_valid, ddr_b_ready, ddr_ar_valid, ddr_ar_ready;
  logic ddr_r_valid, ddr_r_ready, ddr_r_last;
  logic [AXI_ID_W-1:0] ddr_aw_id, ddr_b_id, ddr_ar_id, ddr_r_id;
  logic [DDR_ADDR_W-1:0] ddr_aw_addr, ddr_ar_addr;
  logic [AXI_LEN_W-1:0] ddr_aw_len, ddr_ar_len;
  logic [2:0] ddr_aw_size, ddr_ar_size;
  logic [DDR_DATA_W-1:0] ddr_w_data, ddr_r_data;
  logic [DDR_STRB_W-1:0] ddr_w_strb;
  logic [AXI_RESP_W-1:0] ddr_b_resp, ddr_r_resp;
  logic cnt_enable, cnt_load, cnt_clear, cnt_oneshot, tick, cnt_ge_watermark;
  logic [TICK_W-1:0] tick_value, tick_cnt;
  logic [CNT_W-1:0] cnt_load_value, cnt_watermark, cnt;

  integer seed;
  int error_count, aw_count, w_count, ar_count, b_count, r_count;
  logic traffic_on, cnt_random, sync_q, drained, saw_wrap;
  logic [AW_W-1:0] aw_q[$], ar_q[$];   // expected DDR-side requests
  logic [W_W-1:0]  w_q[$];
  logic [B_W-1:0]  b_q[$];             // expected simulator-side responses
  logic [R_W-1:0]  r_q[$];
  logic [AW_W-1:0] aw_exp, ar_exp;
  logic [W_W-1:0]  w_exp;
  logic [B_W-1:0]  b_exp;
  logic [R_W-1:0]  r_exp;
  // counter model state, controls delayed one cycle
  logic m_en, m_ld, m_clr, m_os, m_tick;
  logic [TICK_W-1:0] m_tv, m_tc;
  logic [CNT_W-1:0]  m_lv, m_wm, m_cnt;

  cl_sim_shell UUT (.*);

  function automatic logic chance(input int pct);   // true pct percent of the time
    chance = (($random(seed) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  function automatic logic [DDR_DATA_W-1:0] rand_wide();
    logic [DDR_DATA_W-1:0] v;
    for (int i = 0; i < DDR_DATA_W / 32; i++)
      v[i*32 +: 32] = $random(seed);
    rand_wide = v;
  endfunction

  function automatic logic [DDR_ADDR_W-1:0] beat_to_byte(input logic [SIM_ADDR_W-1:0] beat);
    beat_to_byte = DDR_ADDR_W'(beat) * 64'd8;   // 8 bytes per simulator beat
  endfunction

  task automatic report(input string msg);
    error_count++;
    $display("error %0t: %s", $time, msg);
  endtask

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  initial
  begin
    #(2 * TOTAL_CYCLES * 10);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("Test failed");
    $finish;
  end

  //------------------------------------------------------------
  // random drivers, valid and payload held until accepted
  //------------------------------------------------------------
  always @(posedge clk_main_a0)
  begin
    if (!sim_aw_valid || sim_aw_ready)
    begin
      sim_aw_valid <= traffic_on && chance(50);
      sim_aw_id    <= $random(seed);
      sim_aw_addr  <= $random(seed);
      sim_aw_len   <= $random(seed);
    end
    if (!sim_w_valid || sim_w_ready)
    begin
      sim_w_valid <= traffic_on && chance(60);
      sim_w_data  <= {$random(seed), $random(seed)};
      sim_w_strb  <= $random(seed);
      sim_w_last  <= chance(25);
    end
    if (!sim_ar_valid || sim_ar_ready)
    begin
      sim_ar_valid <= traffic_on && chance(50);
      sim_ar_id    <= $random(seed);
      sim_ar_addr  <= $random(seed);
      sim_ar_len   <= $random(seed);
    end
    if (!ddr_b_valid || ddr_b_ready)
    begin
      ddr_b_valid <= traffic_on && chance(50);
      ddr_b_id    <= $random(seed);
      ddr_b_resp  <= $random(seed);
    end
    if (!ddr_r_valid || ddr_r_ready)
    begin
      ddr_r_valid <= traffic_on && chance(60);
      ddr_r_id    <= $random(seed);
      ddr_r_data  <= rand_wide();     // upper lanes random, must be dropped
      ddr_r_resp  <= $random(seed);
      ddr_r_last  <= chance(25);
    end
    ddr_aw_ready <= chance(60);     // back-pressure on every ready
    ddr_w_ready  <= chance(60);
    ddr_ar_ready <= chance(60);
    sim_b_ready  <= chance(60);
    sim_r_ready  <= chance(60);
    if (cnt_random)
    begin
      cnt_enable <= chance(85);
      cnt_load   <= chance(5);
      cnt_clear  <= chance(3);
      if (chance(5))
        cnt_oneshot <= chance(50);
      if (chance(5))
        tick_value <= $random(seed) & 8'h07;   // short periods give many ticks
      cnt_load_value <= $random(seed);
      if (chance(10))
        cnt_watermark <= $random(seed);
    end
  end

  //------------------------------------------------------------
  // monitor: scoreboards and counter model, sampled at the edge
  //------------------------------------------------------------
  always @(posedge clk_main_a0)
  begin
    if (UUT.rst_sync_n === 1'b1 && sync_q !== 1'b1)
    begin
      if (ddr_aw_valid || ddr_w_valid || ddr_ar_valid || sim_b_valid || sim_r_valid)
        report("valid output high in first cycle after reset");
      if (sim_aw_ready || sim_w_ready || sim_ar_ready || ddr_b_ready || ddr_r_ready)
        report("ready output high in first cycle after reset");
    end
    sync_q = UUT.rst_sync_n;
    if (UUT.rst_sync_n === 1'b1)
    begin
      if (ddr_aw_valid && ddr_aw_ready)
      begin
        aw_count++;
        if (aw_q.size() == 0)
          report("unexpected AW transfer on DDR side");
        else
        begin
          aw_exp = aw_q.pop_front();
          if ({ddr_aw_id, ddr_aw_addr, ddr_aw_len} !== aw_exp || ddr_aw_size !== 3'b110)
            report($sformatf("AW got %h exp %h",
                             {ddr_aw_id, ddr_aw_addr, ddr_aw_len}, aw_exp));
        end
      end
      if (ddr_ar_valid && ddr_ar_ready)
      begin
        ar_count++;
        if (ar_q.size() == 0)
          report("unexpected AR transfer on DDR side");
        else
        begin
          ar_exp = ar_q.pop_front();
          if ({ddr_ar_id, ddr_ar_addr, ddr_ar_len} !== ar_exp || ddr_ar_size !== 3'b110)
            report($sformatf("AR got %h exp %h",
                             {ddr_ar_id, ddr_ar_addr, ddr_ar_len}, ar_exp));
        end
      end
      if (ddr_w_valid && ddr_w_ready)
      begin
        w_count++;
        if (w_q.size() == 0)
          report("unexpected W transfer on DDR side");
        else
        begin
          w_exp = w_q.pop_front();
          if (ddr_w_data !== {448'h0, w_exp[W_W-1 -: SIM_DATA_W]}
              || ddr_w_strb !== {56'h0, w_exp[SIM_STRB_W:1]} || ddr_w_last !== w_exp[0])
            report($sformatf("W got %h/%h/%b exp %h", ddr_w_data[SIM_DATA_W-1:0],
                             ddr_w_strb, ddr_w_last, w_exp));
        end
      end
      if (sim_b_valid && sim_b_ready)
      begin
        b_count++;
        if (b_q.size() == 0)
          report("unexpected B transfer on simulator side");
        else
        begin
          b_exp = b_q.pop_front();
          if ({sim_b_id, sim_b_resp} !== b_exp)
            report($sformatf("B got %h exp %h", {sim_b_id, sim_b_resp}, b_exp));
        end
      end
      if (sim_r_valid && sim_r_ready)
      begin
        r_count++;
        if (r_q.size() == 0)
          report("unexpected R transfer on simulator side");
        else
        begin
          r_exp = r_q.pop_front();
          if ({sim_r_id, sim_r_data, sim_r_resp, sim_r_last} !== r_exp)
            report($sformatf("R got %h exp %h",
                             {sim_r_id, sim_r_data, sim_r_resp, sim_r_last}, r_exp));
        end
      end
      // accepted inputs become expected outputs
      if (sim_aw_valid && sim_aw_ready)
        aw_q.push_back({sim_aw_id, beat_to_byte(sim_aw_addr), sim_aw_len});
      if (sim_ar_valid && sim_ar_ready)
        ar_q.push_back({sim_ar_id, beat_to_byte(sim_ar_addr), sim_ar_len});
      if (sim_w_valid && sim_w_ready)
        w_q.push_back({sim_w_data, sim_w_strb, sim_w_last});
      if (ddr_b_valid && ddr_b_ready)
        b_q.push_back({ddr_b_id, ddr_b_resp});
      if (ddr_r_valid && ddr_r_ready)
        r_q.push_back({ddr_r_id, ddr_r_data[SIM_DATA_W-1:0], ddr_r_resp, ddr_r_last});

      // counter model
      m_tick = m_en && (m_tc >= m_tv);
      if (tick !== m_tick || tick_cnt !== m_tc || cnt !== m_cnt
          || cnt_ge_watermark !== (m_cnt >= m_wm))
        report($sformatf("counter got %b/%h/%h/%b exp %b/%h/%h/%b",
                         tick, tick_cnt, cnt, cnt_ge_watermark,
                         m_tick, m_tc, m_cnt, m_cnt >= m_wm));
      if (m_clr)
        m_cnt = '0;
      else if (m_ld)
        m_cnt = m_lv;
      else if (m_tick && !(m_os && m_cnt == 16'hffff))
        m_cnt = m_cnt + 1'b1;          // saturates only in one-shot
      if (m_clr)
        m_tc = '0;
      else if (m_en)
        m_tc = (m_tc >= m_tv) ? '0 : m_tc + 1'b1;
      {m_en, m_ld, m_clr, m_os} = {cnt_enable, cnt_load, cnt_clear, cnt_oneshot};
      {m_tv, m_lv, m_wm} = {tick_value, cnt_load_value, cnt_watermark};
    end
    else
    begin
      {m_en, m_ld, m_clr, m_os, m_tv, m_lv, m_wm, m_tc, m_cnt} = '0;   // model in reset
    end
  end

  //------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------
  initial
  begin
    seed = 32'hce58_14b9;
    {error_count, aw_count, w_count, ar_count, b_count, r_count} = '0;
    {traffic_on, cnt_random, sync_q, drained, saw_wrap} = '0;
    rst_main_n = 1'b0;
    {sim_aw_valid, sim_aw_id, sim_aw_addr, sim_aw_len} = '0;
    {sim_w_valid, sim_w_data, sim_w_strb, sim_w_last} = '0;
    {sim_ar_valid, sim_ar_id, sim_ar_addr, sim_ar_len} = '0;
    {sim_b_ready, sim_r_ready, ddr_aw_ready, ddr_w_ready, ddr_ar_ready} = '0;
    {ddr_b_valid, ddr_b_id, ddr_b_resp} = '0;
    {ddr_r_valid, ddr_r_id, ddr_r_data, ddr_r_resp, ddr_r_last} = '0;
    {cnt_enable, cnt_load, cnt_clear, cnt_oneshot, tick_value} = '0;
    {cnt_load_value, cnt_watermark} = '0;
    repeat (RESET_CYCLES) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;
    repeat (4) @(posedge clk_main_a0);
    if (UUT.rst_sync_n !== 1'b1)
      report("reset synchronizer did not release");
    if (cl_id0 !== 32'hF000_1D0F || cl_id1 !== 32'h1D51_FEDC
        || cl_status0 !== 32'h0000_0FF0 || cl_status1 !== 32'hEEEE_EE00)
      report("identity or status word mismatch");
    traffic_on <= 1'b1;
    cnt_random <= 1'b1;
    repeat (TRAFFIC_CYCLES) @(posedge clk_main_a0);
    traffic_on <= 1'b0;
    cnt_random <= 1'b0;
    @(posedge clk_main_a0);         // random counter driver idle from here

    // one-shot: load near the top and hold at all ones
    cnt_enable     <= 1'b0;
    cnt_clear      <= 1'b0;
    cnt_load       <= 1'b1;
    cnt_oneshot    <= 1'b1;
    cnt_load_value <= 16'hfffd;
    tick_value     <= '0;           // tick every enabled cycle
    @(posedge clk_main_a0);
    cnt_load   <= 1'b0;
    cnt_enable <= 1'b1;
    repeat (12) @(posedge clk_main_a0);
    if (cnt !== 16'hffff)
      report($sformatf("one-shot cnt %h exp ffff", cnt));

    // same load without one-shot must wrap
    cnt_enable  <= 1'b0;
    cnt_oneshot <= 1'b0;
    cnt_load    <= 1'b1;
    @(posedge clk_main_a0);
    cnt_load <= 1'b0;
    repeat (3) @(posedge clk_main_a0);
    cnt_enable <= 1'b1;
    for (int i = 0; i < 12; i++)
    begin
      @(posedge clk_main_a0);
      if (cnt === 16'h0000)
        saw_wrap = 1'b1;
    end
    if (!saw_wrap)
      report("counter did not wrap to 0 without one-shot");

    // drain all channels
    for (int i = 0; i < DRAIN_CYCLES && !drained; i++)
    begin
      @(posedge clk_main_a0);
      drained = (aw_q.size() + w_q.size() + ar_q.size() + b_q.size() + r_q.size() == 0)
                && !sim_aw_valid && !sim_w_valid && !sim_ar_valid
                && !ddr_b_valid && !ddr_r_valid;
    end
    if (!drained)
    begin
      error_count++;
      $display("transfers still pending after drain, some were lost in the bridge");
    end

    $display("errors %0d, transfers aw %0d w %0d ar %0d b %0d r %0d",
             error_count, aw_count, w_count, ar_count, b_count, r_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
